//--- common/quark_defines.svh
`ifndef QUARK_DEFINES_SVH
`define QUARK_DEFINES_SVH

// Width of a data word and of the register file entries
`define QUARK_XLEN 32

// Internal address width, zero-extended at the memory bus
`define QUARK_PC_WIDTH 24

// First instruction fetched after reset
`define QUARK_RESET_ADDR 0

// Number of integer registers, x0 included
`define QUARK_REG_COUNT 32

// Widest shift amount
`define QUARK_SHAMT_WIDTH 5

`endif

//--- common/isaPkg.sv
`default_nettype none

package isaPkg;

  // Instruction kinds, encoded as instruction bits 6 to 2
  typedef enum logic [4:0] {
    opLoad   = 5'b00000,
    opAluImm = 5'b00100,
    opAuipc  = 5'b00101,
    opStore  = 5'b01000,
    opAluReg = 5'b01100,
    opLui    = 5'b01101,
    opBranch = 5'b11000,
    opJalr   = 5'b11001,
    opJal    = 5'b11011,
    // SYSTEM, FENCE and anything unknown
    opOther  = 5'b11111
  } opcodeT;

  // The funct3 field, bits 14 to 12
  typedef logic [2:0] funct3T;

  // ALU operations selected by funct3
  localparam funct3T f3AddSub = 3'd0;
  localparam funct3T f3Sll    = 3'd1;
  localparam funct3T f3Slt    = 3'd2;
  localparam funct3T f3Sltu   = 3'd3;
  localparam funct3T f3Xor    = 3'd4;
  localparam funct3T f3SrlSra = 3'd5;
  localparam funct3T f3Or     = 3'd6;
  localparam funct3T f3And    = 3'd7;

  // Branch conditions selected by funct3
  localparam funct3T f3Beq  = 3'd0;
  localparam funct3T f3Bne  = 3'd1;
  localparam funct3T f3Blt  = 3'd4;
  localparam funct3T f3Bge  = 3'd5;
  localparam funct3T f3Bltu = 3'd6;
  localparam funct3T f3Bgeu = 3'd7;

endpackage

`default_nettype wire

//--- common/corePkg.sv
`default_nettype none

`include "quark_defines.svh"

package corePkg;

  // One data word
  typedef logic [`QUARK_XLEN-1:0] wordT;

  // Internal address, narrower than a word
  typedef logic [`QUARK_PC_WIDTH-1:0] addrT;

  // Register index
  typedef logic [$clog2(`QUARK_REG_COUNT)-1:0] regIdT;

  // Sequencer states, one-hot
  typedef enum logic [3:0] {
    // Read strobe for the instruction
    stFetch      = 4'b0001,
    // Waiting for the instruction word
    stWaitInstr  = 4'b0010,
    // PC update, memory request, shift start
    stExecute    = 4'b0100,
    // Waiting for the shifter or the bus
    stWaitAluMem = 4'b1000
  } coreStateT;

endpackage

`default_nettype wire

//--- common/decodeIf.sv
`timescale 1ns/1ps
`default_nettype none

// Decoded fields of the latched instruction
interface decodeIf import isaPkg::*, corePkg::*;;

  // Instruction kind
  opcodeT opcode;
  // ALU operation or branch condition
  funct3T funct3;
  // Destination register
  regIdT  rdId;
  // Immediate of the instruction's own format
  wordT   imm;
  // SUB or arithmetic right shift
  logic   altFunc;

  modport decoder (output opcode, funct3, rdId, imm, altFunc);

  modport exec (input opcode, funct3, imm, altFunc);

  // funct3 tells the sequencer whether an ALU op is a shift
  modport ctrl (input opcode, funct3, imm);

  modport result (input opcode, rdId, imm);

endinterface

`default_nettype wire

//--- design/instrDecoder.sv
`timescale 1ns/1ps
`default_nettype none

module instrDecoder import isaPkg::*, corePkg::*;
(
  input  logic    clk,
  input  logic    reset,
  input  logic    instrLoad,
  input  wordT    fetchWord,
  output regIdT   rs1Id,
  output regIdT   rs2Id,
  decodeIf.decoder dec
);

  // Bits 1 and 0 are always 11 in RV32I, not kept
  logic [31:2] instr;
  opcodeT      opcode;

  always_ff @(posedge clk)
  begin
    if (!reset)
      instr <= '0;
    else if (instrLoad)
      instr <= fetchWord[31:2];
  end

  // Source indices come from the bus word, so the register file
  // can be read on the same edge that latches the instruction
  assign rs1Id = fetchWord[19:15];
  assign rs2Id = fetchWord[24:20];

  // Known opcodes map onto themselves
  always_comb
  begin
    case (instr[6:2])
      opLoad, opAluImm, opAuipc, opStore, opAluReg,
      opLui, opBranch, opJalr, opJal:
        opcode = opcodeT'(instr[6:2]);
      default:
        opcode = opOther;
    endcase
  end

  // Immediate of the instruction's format
  always_comb
  begin
    case (opcode)
      opLoad, opAluImm, opJalr:
        dec.imm = {{21{instr[31]}}, instr[30:20]};
      opStore:
        dec.imm = {{21{instr[31]}}, instr[30:25], instr[11:7]};
      opBranch:
        dec.imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
      opJal:
        dec.imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
      opLui, opAuipc:
        dec.imm = {instr[31:12], 12'b0};
      default:
        dec.imm = '0;
    endcase
  end

  assign dec.opcode = opcode;
  assign dec.funct3 = instr[14:12];
  assign dec.rdId   = instr[11:7];

  // Bit 30 is part of the I immediate for ADDI, so only SRAI looks at it
  assign dec.altFunc = instr[30] & ((opcode == opAluReg) |
                       ((opcode == opAluImm) & (instr[14:12] == f3SrlSra)));

endmodule

`default_nettype wire

//--- execute/alu.sv
`timescale 1ns/1ps
`default_nettype none

`include "quark_defines.svh"

module alu import isaPkg::*, corePkg::*;
(
  input  logic     clk,
  input  logic     reset,
  decodeIf.exec    dec,
  input  wordT     rs1,
  input  wordT     rs2,
  input  logic     aluStart,
  output wordT     aluOut,
  output wordT     aluSum,
  output logic     aluBusy,
  output logic     takeBranch
);

  wordT                          aluIn2;
  wordT                          aluPlus;
  logic [`QUARK_XLEN:0]          aluMinus;
  logic                          lt;
  logic                          ltu;
  logic                          eq;
  logic                          isShift;
  wordT                          shiftReg;
  logic [`QUARK_SHAMT_WIDTH-1:0] shamt;

  // Register operand for R-type and branches, immediate otherwise
  assign aluIn2 = ((dec.opcode == opAluReg) | (dec.opcode == opBranch)) ? rs2 : dec.imm;

  // Shared adder, also the JALR target and the load/store address
  assign aluPlus = rs1 + aluIn2;
  assign aluSum  = aluPlus;

  // One wide subtract gives all three comparisons
  assign aluMinus = {1'b0, rs1} - {1'b0, aluIn2};
  assign ltu      = aluMinus[`QUARK_XLEN];
  // Differing signs decide on their own
  assign lt       = (rs1[`QUARK_XLEN-1] ^ aluIn2[`QUARK_XLEN-1]) ?
                    rs1[`QUARK_XLEN-1] : aluMinus[`QUARK_XLEN];
  assign eq       = (aluMinus[`QUARK_XLEN-1:0] == '0);

  assign isShift = (dec.funct3 == f3Sll) | (dec.funct3 == f3SrlSra);

  // Busy while bits remain to shift
  assign aluBusy = |shamt;

  always_ff @(posedge clk)
  begin
    if (!reset)
      shamt <= '0;
    else if (aluStart & isShift)
      shamt <= aluIn2[`QUARK_SHAMT_WIDTH-1:0];
    else if (aluBusy)
      shamt <= shamt - 1'b1;
  end

  // One bit per cycle, sign fill only for SRA
  always_ff @(posedge clk)
  begin
    if (aluStart & isShift)
      shiftReg <= rs1;
    else if (aluBusy)
      shiftReg <= (dec.funct3 == f3Sll) ? {shiftReg[`QUARK_XLEN-2:0], 1'b0} :
                  {dec.altFunc & shiftReg[`QUARK_XLEN-1], shiftReg[`QUARK_XLEN-1:1]};
  end

  always_comb
  begin
    case (dec.funct3)
      f3AddSub: aluOut = dec.altFunc ? aluMinus[`QUARK_XLEN-1:0] : aluPlus;
      f3Sll:    aluOut = shiftReg;
      f3Slt:    aluOut = {{(`QUARK_XLEN-1){1'b0}}, lt};
      f3Sltu:   aluOut = {{(`QUARK_XLEN-1){1'b0}}, ltu};
      f3Xor:    aluOut = rs1 ^ aluIn2;
      f3SrlSra: aluOut = shiftReg;
      f3Or:     aluOut = rs1 | aluIn2;
      f3And:    aluOut = rs1 & aluIn2;
    endcase
  end

  // Branch predicate, the sequencer qualifies it with the opcode
  always_comb
  begin
    case (dec.funct3)
      f3Beq:   takeBranch = eq;
      f3Bne:   takeBranch = ~eq;
      f3Blt:   takeBranch = lt;
      f3Bge:   takeBranch = ~lt;
      f3Bltu:  takeBranch = ltu;
      f3Bgeu:  takeBranch = ~ltu;
      default: takeBranch = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

//--- design/coreControl.sv
`timescale 1ns/1ps
`default_nettype none

`include "quark_defines.svh"

module coreControl import isaPkg::*, corePkg::*;
(
  input  logic       clk,
  input  logic       reset,
  decodeIf.ctrl      dec,
  input  wordT       aluSum,
  input  logic       aluBusy,
  input  logic       takeBranch,
  input  logic       memRbusy,
  input  logic       memWbusy,
  output addrT       memAddr,
  output logic       memRstrb,
  output logic [3:0] memWmask,
  output logic       instrLoad,
  output logic       aluStart,
  output logic       wbEnable,
  output addrT       pcPlus4,
  output addrT       pcPlusImm
);

  coreStateT state;
  addrT      pc;
  addrT      nextPc;
  logic      isAlu;
  logic      isShift;
  logic      jumpToImm;
  logic      needWait;

  assign isAlu   = (dec.opcode == opAluImm) | (dec.opcode == opAluReg);
  assign isShift = (dec.funct3 == f3Sll) | (dec.funct3 == f3SrlSra);

  assign pcPlus4   = pc + addrT'(4);
  // Immediate is J, B or U depending on the opcode
  assign pcPlusImm = pc + dec.imm[`QUARK_PC_WIDTH-1:0];

  assign jumpToImm = (dec.opcode == opJal) | ((dec.opcode == opBranch) & takeBranch);

  // JALR clears bit 0 of its target
  assign nextPc = (dec.opcode == opJalr) ? {aluSum[`QUARK_PC_WIDTH-1:1], 1'b0} :
                  jumpToImm ? pcPlusImm : pcPlus4;

  // Loads, stores and shifts need the wait state
  assign needWait = (dec.opcode == opLoad) | (dec.opcode == opStore) | (isAlu & isShift);

  // Instruction address during fetch, data address otherwise
  assign memAddr = ((state == stFetch) | (state == stWaitInstr)) ?
                   pc : aluSum[`QUARK_PC_WIDTH-1:0];

  assign memRstrb  = (state == stFetch) | ((state == stExecute) & (dec.opcode == opLoad));
  // Word stores only
  assign memWmask  = {4{(state == stExecute) & (dec.opcode == opStore)}};
  assign instrLoad = (state == stWaitInstr) & ~memRbusy;
  assign aluStart  = (state == stExecute) & isAlu;
  // Opcode filtering happens in write-back
  assign wbEnable  = (state == stExecute) | (state == stWaitAluMem);

  always_ff @(posedge clk)
  begin
    if (!reset)
    begin
      // Start by waiting for the bus to go idle
      state <= stWaitAluMem;
      pc    <= addrT'(`QUARK_RESET_ADDR);
    end
    else
    begin
      case (state)
        stFetch:
          state <= stWaitInstr;
        stWaitInstr:
          if (!memRbusy)
            state <= stExecute;
        stExecute:
        begin
          pc    <= nextPc;
          state <= needWait ? stWaitAluMem : stFetch;
        end
        stWaitAluMem:
          if (!aluBusy & !memRbusy & !memWbusy)
            state <= stFetch;
        default:
          state <= stWaitAluMem;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- design/writeBack.sv
`timescale 1ns/1ps
`default_nettype none

`include "quark_defines.svh"

module writeBack import isaPkg::*, corePkg::*;
(
  input  logic      clk,
  decodeIf.result   dec,
  input  logic      instrLoad,
  input  regIdT     rs1Id,
  input  regIdT     rs2Id,
  input  logic      wbEnable,
  input  wordT      aluOut,
  input  addrT      pcPlus4,
  input  addrT      pcPlusImm,
  input  wordT      memRdata,
  output wordT      rs1,
  output wordT      rs2
);

  wordT regFile [`QUARK_REG_COUNT];
  wordT wbData;
  logic wbValid;

  // Operands latched together with the instruction, x0 forced to zero
  always_ff @(posedge clk)
  begin
    if (instrLoad)
    begin
      rs1 <= (rs1Id == '0) ? '0 : regFile[rs1Id];
      rs2 <= (rs2Id == '0) ? '0 : regFile[rs2Id];
    end
  end

  // Result source by opcode
  always_comb
  begin
    wbValid = 1'b1;
    case (dec.opcode)
      opLui:             wbData = dec.imm;
      opAluImm, opAluReg: wbData = aluOut;
      opAuipc:           wbData = wordT'(pcPlusImm);
      opJal, opJalr:     wbData = wordT'(pcPlus4);
      opLoad:            wbData = memRdata;
      default:
      begin
        // Branches, stores and the rest leave rd alone
        wbValid = 1'b0;
        wbData  = '0;
      end
    endcase
  end

  // Rewritten every wait cycle, the last one holds the final value
  always_ff @(posedge clk)
  begin
    if (wbEnable & wbValid & (dec.rdId != '0))
      regFile[dec.rdId] <= wbData;
  end

endmodule

`default_nettype wire

//--- design/quarkCore.sv
`timescale 1ns/1ps
`default_nettype none

module quarkCore import corePkg::*;
(
  input  logic       clk,
  input  logic       reset,
  output wordT       memAddr,
  output wordT       memWdata,
  output logic [3:0] memWmask,
  input  wordT       memRdata,
  output logic       memRstrb,
  input  logic       memRbusy,
  input  logic       memWbusy
);

  // Decoded fields of the current instruction
  decodeIf decBus ();

  regIdT rs1Id;
  regIdT rs2Id;
  wordT  rs1;
  wordT  rs2;
  wordT  aluOut;
  wordT  aluSum;
  logic  aluBusy;
  logic  takeBranch;
  logic  instrLoad;
  logic  aluStart;
  logic  wbEnable;
  addrT  pcPlus4;
  addrT  pcPlusImm;
  addrT  coreAddr;

  // Store data is always the full rs2 word
  assign memWdata = rs2;
  assign memAddr  = wordT'(coreAddr);

  instrDecoder instrDecoder_i (
    .clk(clk), .reset(reset), .instrLoad(instrLoad), .fetchWord(memRdata),
    .rs1Id(rs1Id), .rs2Id(rs2Id), .dec(decBus.decoder)
  );

  alu alu_i (
    .clk(clk), .reset(reset), .dec(decBus.exec), .rs1(rs1), .rs2(rs2),
    .aluStart(aluStart), .aluOut(aluOut), .aluSum(aluSum),
    .aluBusy(aluBusy), .takeBranch(takeBranch)
  );

  coreControl coreControl_i (
    .clk(clk), .reset(reset), .dec(decBus.ctrl), .aluSum(aluSum),
    .aluBusy(aluBusy), .takeBranch(takeBranch), .memRbusy(memRbusy),
    .memWbusy(memWbusy), .memAddr(coreAddr), .memRstrb(memRstrb),
    .memWmask(memWmask), .instrLoad(instrLoad), .aluStart(aluStart),
    .wbEnable(wbEnable), .pcPlus4(pcPlus4), .pcPlusImm(pcPlusImm)
  );

  writeBack writeBack_i (
    .clk(clk), .dec(decBus.result), .instrLoad(instrLoad), .rs1Id(rs1Id),
    .rs2Id(rs2Id), .wbEnable(wbEnable), .aluOut(aluOut), .pcPlus4(pcPlus4),
    .pcPlusImm(pcPlusImm), .memRdata(memRdata), .rs1(rs1), .rs2(rs2)
  );

endmodule

`default_nettype wire

//--- sim/quarkCoreTb.sv
`timescale 1ns/1ps
`default_nettype none

module quarkCoreTb import corePkg::*;
();

  // Two counts, 80 program words, 22 store records and the done address
  localparam int caseWords = 127;
  // 4 KiB memory model
  localparam int memWords  = 1024;
  // Two LFSR bits per stall
  localparam int maxStall  = 3;

  logic        clk;
  logic        reset;
  wordT        memAddr;
  wordT        memWdata;
  logic [3:0]  memWmask;
  wordT        memRdata;
  logic        memRstrb;
  logic        memRbusy;
  logic        memWbusy;

  wordT        caseData [caseWords];
  wordT        mem [memWords];
  wordT        doneAddr;
  int          progCount;
  int          recCount;
  int          recBase;
  int          recIdx;
  int          readStall;
  int          writeStall;
  logic [15:0] lfsr;
  bit          loaded;
  bit          doneSeen;

  quarkCore quarkCore_i (
    .clk(clk), .reset(reset), .memAddr(memAddr), .memWdata(memWdata),
    .memWmask(memWmask), .memRdata(memRdata), .memRstrb(memRstrb),
    .memRbusy(memRbusy), .memWbusy(memWbusy)
  );

  // 10 ns period
  always
  begin
    #5 clk = ~clk;
  end

  task automatic failRun(input string reason);
    $display("%s", reason);
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic checkAddr(input string testName, input wordT expected, input wordT actual);
    if (actual !== expected)
      failRun($sformatf("ERROR %s: expected address %h, actual %h",
                        testName, expected, actual));
  endtask

  task automatic checkWord(input string testName, input wordT expected, input wordT actual);
    if (actual !== expected)
      failRun($sformatf("ERROR %s: expected data %h, actual %h",
                        testName, expected, actual));
  endtask

  // Galois LFSR, x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsrNext(input logic [15:0] state);
    return state[0] ? ((state >> 1) ^ 16'hB400) : (state >> 1);
  endfunction

  // Stall of 0 to 3 cycles, one LFSR step per bit
  task automatic drawStall(output int cycles);
    cycles = 0;
    repeat (2)
    begin
      cycles = (cycles << 1) | lfsr[0];
      lfsr   = lfsrNext(lfsr);
    end
  endtask

  // One store against the next record, then into memory
  task automatic takeStore();
    string name;
    name = $sformatf("store record %0d", recIdx);
    if (memWmask !== 4'b1111)
      failRun($sformatf("store to %h has write mask %b", memAddr, memWmask));
    else if (memAddr >= wordT'(memWords * 4))
      failRun($sformatf("store to %h lies outside the memory model", memAddr));
    else if ((memAddr != doneAddr) && (recIdx >= recCount))
      failRun($sformatf("store of %h to %h came after the last expected store",
                        memWdata, memAddr));
    else
    begin
      if (memAddr == doneAddr)
        doneSeen = 1'b1;
      else
      begin
        checkAddr(name, caseData[recBase + 2 * recIdx], memAddr);
        checkWord(name, caseData[recBase + 2 * recIdx + 1], memWdata);
        recIdx = recIdx + 1;
      end
      mem[memAddr[11:2]] = memWdata;
      drawStall(writeStall);
      memWbusy <= (writeStall > 0);
    end
  endtask

  // Memory model, answers on the cycle after the request
  always @(posedge clk)
  begin
    if (reset)
    begin
      // Busy levels count down while read data stays put
      if (readStall > 0)
      begin
        readStall = readStall - 1;
        memRbusy <= (readStall > 0);
      end
      if (writeStall > 0)
      begin
        writeStall = writeStall - 1;
        memWbusy <= (writeStall > 0);
      end
      if (memRstrb === 1'b1)
      begin
        if (memAddr >= wordT'(memWords * 4))
          failRun($sformatf("read from %h lies outside the memory model", memAddr));
        else
        begin
          memRdata <= mem[memAddr[11:2]];
          drawStall(readStall);
          memRbusy <= (readStall > 0);
        end
      end
      if (memWmask !== 4'b0000)
        takeStore();
    end
  end

  initial
  begin
    int i;
    clk        = 1'b0;
    reset      = 1'b0;
    memRdata   = '0;
    memRbusy   = 1'b0;
    memWbusy   = 1'b0;
    lfsr       = 16'd66;
    readStall  = 0;
    writeStall = 0;
    recIdx     = 0;
    $readmemh("sim/quark_cases.txt", caseData);
    progCount = caseData[0];
    recCount  = caseData[1];
    recBase   = 2 + progCount;
    if ($isunknown(caseData[caseWords - 1]) || (recBase + 2 * recCount + 1 != caseWords))
      failRun("the case file does not match its own word counts");
    else
    begin
      // Unused words carry their own index
      for (i = 0; i < memWords; i++)
        mem[i] = 32'hbad00000 ^ wordT'(i);
      for (i = 0; i < progCount; i++)
        mem[i] = caseData[2 + i];
      doneAddr = caseData[recBase + 2 * recCount];
      loaded   = 1'b1;
      repeat (16) @(posedge clk);
      reset <= 1'b1;
      wait (doneSeen);
      if (recIdx == recCount)
      begin
        $display("Test passed");
        $finish;
      end
      else
        failRun($sformatf("done address stored after only %0d of %0d expected stores",
                          recIdx, recCount));
    end
  end

  // Watchdog
  initial
  begin
    wait (loaded);
    // 40 cycles per program word, stretched by the worst stall
    repeat (progCount * 40 * (maxStall + 1)) @(posedge clk);
    failRun("timeout, the program never stored to the done address");
  end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+common
common/isaPkg.sv
common/corePkg.sv
common/decodeIf.sv
design/instrDecoder.sv
execute/alu.sv
design/coreControl.sv
design/writeBack.sv
design/quarkCore.sv
sim/quarkCoreTb.sv

//--- sim/quark_cases.txt
// Program word count and store record count, then the program words,
// then one address and data pair per expected store, then the done address
00000050 00000016
// ALU register and immediate operations
40000093 06400113 FF900193 00310233  // x1=0x400 x2=100 x3=-7 add x4
0040A023 402182B3 0050A223 0021A333  // sw x4 then sub x5 and sw x5 then slt x6
0021B3B3 0060A423 0070A623 0F01C413  // sltu x7 then sw x6 and x7 then xori x8
00646493 0024F533 00A0A823 0090AA23  // ori x9 and x10 then sw x10 and x9
// Serial shifts by 0, 1 and 31
00119593 4011D613 01F1D693 00011733  // slli 1 then srai 1 then srli 31 then sll 0
01F00813 4101D7B3 01F19893 00B0AC23  // x16=31 then sra 31 then slli 31 then sw x11
00C0AE23 02D0A023 02E0A223 02F0A423  // sw x12 to x15
// Taken branches skip poison adds to x20
0310A623 00000A13 00000A93 00210463  // sw x17 then clear x20 and x21 then beq
001A0A13 00311463 002A0A13 0021C463  // bne then blt
004A0A13 00315463 008A0A13 00316463  // bge then bltu
// Branches not taken fall into marker adds to x21
010A0A13 0021F463 020A0A13 00310463  // bgeu taken then beq not taken
001A8A93 00211463 002A8A93 00314463  // bne then blt
004A8A93 0021D463 008A8A93 0021E463  // bge then bltu
010A8A93 00317463 020A8A93 0340A823  // bgeu then sw x20
// Jumps and upper immediates
0350AA23 00800B6F 00100B13 00000B97  // sw x21 then jal x22 over a poison then auipc x23
011B8C67 00200C13 00300C13 0360AC23  // jalr x24 to an odd target then sw x22
0380AE23 12345CB7 00012D17 0590A023  // sw x24 then lui x25 and auipc x26 then sw x25
// Store then load back, and writes to x0
05A0A223 003C8DB3 05B0A423 0480AE03  // sw x26 then x27 stored and loaded into x28
005E0013 000E0EB3 05D0A623 0400A823  // addi x0 then x29=x28+x0 then sw x29 and x0
0040AF03 05E0AA23 4000A023 0000006F  // reload sub result then store to done address
// Expected stores, address then data
00000400 0000005D 00000404 FFFFFF95  // add and sub
00000408 00000001 0000040C 00000000  // slt and sltu
00000410 00000004 00000414 FFFFFF0F  // and then xor with or
00000418 FFFFFFF2 0000041C FFFFFFFC  // slli 1 and srai 1
00000420 00000001 00000424 00000064  // srli 31 and sll 0
00000428 FFFFFFFF 0000042C 80000000  // sra 31 and slli 31
00000430 00000000 00000434 0000003F  // no poison and all six markers
00000438 000000E8 0000043C 000000F4  // jal and jalr links
00000440 12345000 00000444 00012108  // lui and auipc
00000448 12344FF9 0000044C 12344FF9  // stored word and its load
00000450 00000000 00000454 FFFFFF95  // x0 and an older word loaded back
// Done address
00000800
